/* logic/mem_cfg_pkg.sv */
`default_nettype none
// **************************************************
// Configuration constants for the local memory subsystem.
// Bank geometry, register stage counts, queue sizing and the
// refresh schedule are all set here and shared by every block
// **************************************************

package mem_cfg_pkg;

    // Word addressed bank of 256 words, 32 bits each
    localparam int MEM_ADDR_WIDTH = 8;
    localparam int MEM_DATA_WIDTH = 32;
    localparam int MEM_BE_WIDTH = MEM_DATA_WIDTH / 8;

    // Register stages between the arbiter and the bank
    localparam int MEM_REG_STAGES = 2;
    localparam int MEM_WAITREQUEST_STAGES = MEM_REG_STAGES;

    // Entries the bank still has free when it raises waitrequest.
    // Requests already in the stages and those accepted while the
    // waitrequest travels back must all fit, plus one spare
    localparam int MEM_WAITREQUEST_SLACK = MEM_REG_STAGES + MEM_WAITREQUEST_STAGES + 1;

    localparam int MEM_REQ_QUEUE_DEPTH = 16;
    localparam int MEM_REQ_QUEUE_PTR_WIDTH = $clog2(MEM_REQ_QUEUE_DEPTH);
    localparam int MEM_REQ_QUEUE_CNT_WIDTH = $clog2(MEM_REQ_QUEUE_DEPTH + 1);
    localparam int MEM_WAITREQUEST_LEVEL = MEM_REQ_QUEUE_DEPTH - MEM_WAITREQUEST_SLACK;

    // Cycles from issuing a read to its readdatavalid
    localparam int MEM_READ_LATENCY = 2;

    // The bank pauses for MEM_REFRESH_CYCLES out of every interval
    localparam int MEM_REFRESH_INTERVAL = 64;
    localparam int MEM_REFRESH_CYCLES = 6;
    localparam int MEM_REFRESH_CNT_WIDTH = $clog2(MEM_REFRESH_INTERVAL);

    // Reads that can be in flight behind the arbiter at once
    localparam int MEM_MAX_OUTSTANDING =
        MEM_REQ_QUEUE_DEPTH + MEM_READ_LATENCY + 2 * MEM_REG_STAGES;
    localparam int MEM_ORDER_PTR_WIDTH = $clog2(MEM_MAX_OUTSTANDING);
    localparam int MEM_ORDER_CNT_WIDTH = $clog2(MEM_MAX_OUTSTANDING + 1);

endpackage

`default_nettype wire

/* logic/mem_if_pkg.sv */
`default_nettype none
// **************************************************
// Request and response types of the Avalon-MM style links
// inside the memory subsystem, plus the port index that the
// arbiter uses to route read data back to its master
// **************************************************

package mem_if_pkg;

    import mem_cfg_pkg::*;

    // One single-word request. At most one of read and write is set,
    // and the request counts only in a cycle with waitrequest low
    typedef struct packed {
        logic read;
        logic write;
        logic [MEM_ADDR_WIDTH-1:0] address;
        logic [MEM_DATA_WIDTH-1:0] writedata;
        // One bit per byte lane of writedata
        logic [MEM_BE_WIDTH-1:0] byteenable;
    } mem_req_t;

    // Read response. There is no back-pressure on this path, so a
    // receiver must take readdata in the cycle readdatavalid is high
    typedef struct packed {
        logic readdatavalid;
        logic [MEM_DATA_WIDTH-1:0] readdata;
    } mem_rsp_t;

    // Index of a request port on the arbiter
    typedef logic master_id_t;

endpackage

`default_nettype wire

/* logic/avalon_mem_if_reg_simple.sv */
`timescale 1ns/1ns
`default_nettype none
// **************************************************
// Register stages on an Avalon-MM link. Requests and read data are
// delayed by N_REG_STAGES, waitrequest by N_WAITREQUEST_STAGES, so
// the slave side must treat its waitrequest as almost full
// **************************************************

module avalon_mem_if_reg_simple
#(
    parameter int N_REG_STAGES = mem_cfg_pkg::MEM_REG_STAGES,
    parameter int N_WAITREQUEST_STAGES = N_REG_STAGES
)
(
    input  wire logic mem_fiu,
    input  wire logic reset,

    // Side facing the arbiter
    input  mem_if_pkg::mem_req_t afu_req,
    output logic afu_waitrequest,
    output mem_if_pkg::mem_rsp_t arb_rsp,

    // Side facing the bank
    output mem_if_pkg::mem_req_t bank_req,
    input  wire logic bank_waitrequest,
    input  mem_if_pkg::mem_rsp_t bank_rsp
);

    import mem_if_pkg::*;

    mem_req_t req_entry;

    // Only accepted requests enter the pipe. The master holds a refused
    // request, so passing it on as well would duplicate it
    always_comb
    begin
        req_entry = afu_req;
        req_entry.read = afu_req.read && !afu_waitrequest;
        req_entry.write = afu_req.write && !afu_waitrequest;
    end

    generate
        if (N_REG_STAGES == 0)
        begin : g_req_wires
            assign bank_req = req_entry;
            assign arb_rsp = bank_rsp;
        end
        else
        begin : g_req_regs
            // Stage 0 is nearest the arbiter for requests and nearest
            // the bank for responses
            mem_req_t req_stage [N_REG_STAGES];
            mem_rsp_t rsp_stage [N_REG_STAGES];

            always_ff @(posedge mem_fiu)
            begin
                req_stage[0] <= req_entry;
                rsp_stage[0] <= bank_rsp;
                for (int i = 1; i < N_REG_STAGES; i++)
                begin
                    req_stage[i] <= req_stage[i-1];
                    rsp_stage[i] <= rsp_stage[i-1];
                end

                // Only the command and valid bits are cleared
                if (reset)
                begin
                    for (int i = 0; i < N_REG_STAGES; i++)
                    begin
                        req_stage[i].read <= 1'b0;
                        req_stage[i].write <= 1'b0;
                        rsp_stage[i].readdatavalid <= 1'b0;
                    end
                end
            end

            assign bank_req = req_stage[N_REG_STAGES-1];
            assign arb_rsp = rsp_stage[N_REG_STAGES-1];
        end

        if (N_WAITREQUEST_STAGES == 0)
        begin : g_wr_wire
            assign afu_waitrequest = bank_waitrequest;
        end
        else
        begin : g_wr_regs
            // Waitrequest shift register, bank side enters at bit 0.
            // All ones after reset keeps the arbiter off until the bank
            // has reported space through every stage
            logic [N_WAITREQUEST_STAGES-1:0] wr_shift;

            always_ff @(posedge mem_fiu)
            begin
                if (reset)
                begin
                    wr_shift <= '1;
                end
                else
                begin
                    wr_shift[0] <= bank_waitrequest;
                    for (int i = 1; i < N_WAITREQUEST_STAGES; i++)
                    begin
                        wr_shift[i] <= wr_shift[i-1];
                    end
                end
            end

            assign afu_waitrequest = wr_shift[N_WAITREQUEST_STAGES-1];
        end
    endgenerate

endmodule

`default_nettype wire

/* logic/mem_arbiter.sv */
`timescale 1ns/1ns
`default_nettype none
// **************************************************
// Round-robin arbiter for two Avalon-MM request ports. Grants are
// combinational; an order queue of port ids steers returning read
// data to the master that issued the read
// **************************************************

module mem_arbiter
(
    input  wire logic mem_fiu,
    input  wire logic reset,

    input  mem_if_pkg::mem_req_t m0_req,
    output logic m0_waitrequest,
    output mem_if_pkg::mem_rsp_t m0_rsp,

    input  mem_if_pkg::mem_req_t m1_req,
    output logic m1_waitrequest,
    output mem_if_pkg::mem_rsp_t m1_rsp,

    output mem_if_pkg::mem_req_t arb_req,
    input  wire logic arb_waitrequest,
    input  mem_if_pkg::mem_rsp_t arb_rsp
);

    import mem_cfg_pkg::*;
    import mem_if_pkg::*;

    logic m0_valid;
    logic m1_valid;
    master_id_t rr_ptr;
    master_id_t grant;
    mem_req_t gnt_req;
    logic accept;

    // Order queue of port ids, one entry per outstanding read
    master_id_t order_q [MEM_MAX_OUTSTANDING];
    logic [MEM_ORDER_PTR_WIDTH-1:0] oq_wr_ptr;
    logic [MEM_ORDER_PTR_WIDTH-1:0] oq_rd_ptr;
    logic [MEM_ORDER_CNT_WIDTH-1:0] oq_cnt;
    logic oq_full;
    logic oq_push;
    logic oq_pop;
    master_id_t oq_head;

    assign m0_valid = m0_req.read || m0_req.write;
    assign m1_valid = m1_req.read || m1_req.write;

    // rr_ptr names the port that wins a tie. A lone requester always wins
    always_comb
    begin
        if (m0_valid && m1_valid)
            grant = rr_ptr;
        else if (m1_valid)
            grant = 1'b1;
        else
            grant = 1'b0;
    end

    assign gnt_req = grant ? m1_req : m0_req;
    assign oq_full = (oq_cnt == MEM_ORDER_CNT_WIDTH'(MEM_MAX_OUTSTANDING));

    // A full order queue holds every request off, writes included
    always_comb
    begin
        arb_req = gnt_req;
        arb_req.read = gnt_req.read && !oq_full;
        arb_req.write = gnt_req.write && !oq_full;
    end

    assign m0_waitrequest = grant || arb_waitrequest || oq_full;
    assign m1_waitrequest = !grant || arb_waitrequest || oq_full;

    assign accept = (arb_req.read || arb_req.write) && !arb_waitrequest;
    assign oq_push = accept && arb_req.read;
    assign oq_pop = arb_rsp.readdatavalid;
    assign oq_head = order_q[oq_rd_ptr];

    // After each acceptance the other port gets priority
    always_ff @(posedge mem_fiu)
    begin
        if (reset)
            rr_ptr <= 1'b0;
        else if (accept)
            rr_ptr <= !grant;
    end

    always_ff @(posedge mem_fiu)
    begin
        if (oq_push)
            order_q[oq_wr_ptr] <= grant;
    end

    // Pointers wrap by hand since the depth is not a power of two
    always_ff @(posedge mem_fiu)
    begin
        if (reset)
        begin
            oq_wr_ptr <= '0;
            oq_rd_ptr <= '0;
            oq_cnt <= '0;
        end
        else
        begin
            if (oq_push)
            begin
                if (oq_wr_ptr == MEM_ORDER_PTR_WIDTH'(MEM_MAX_OUTSTANDING - 1))
                    oq_wr_ptr <= '0;
                else
                    oq_wr_ptr <= oq_wr_ptr + 1'b1;
            end
            if (oq_pop)
            begin
                if (oq_rd_ptr == MEM_ORDER_PTR_WIDTH'(MEM_MAX_OUTSTANDING - 1))
                    oq_rd_ptr <= '0;
                else
                    oq_rd_ptr <= oq_rd_ptr + 1'b1;
            end
            if (oq_push && !oq_pop)
                oq_cnt <= oq_cnt + 1'b1;
            else if (!oq_push && oq_pop)
                oq_cnt <= oq_cnt - 1'b1;
        end
    end

    // Read data fans out to both ports, only the owner sees it valid
    always_comb
    begin
        m0_rsp = arb_rsp;
        m1_rsp = arb_rsp;
        m0_rsp.readdatavalid = arb_rsp.readdatavalid && !oq_head;
        m1_rsp.readdatavalid = arb_rsp.readdatavalid && oq_head;
    end

endmodule

`default_nettype wire

/* logic/local_mem_bank.sv */
`timescale 1ns/1ns
`default_nettype none
// **************************************************
// Local memory bank with a request queue in front. Waitrequest is an
// almost-full flag, the bank stalls periodically for refresh and
// reads return a fixed number of cycles after they are issued
// **************************************************

module local_mem_bank
(
    input  wire logic mem_fiu,
    input  wire logic reset,

    input  mem_if_pkg::mem_req_t bank_req,
    output logic bank_waitrequest,
    output mem_if_pkg::mem_rsp_t bank_rsp
);

    import mem_cfg_pkg::*;
    import mem_if_pkg::*;

    logic [MEM_DATA_WIDTH-1:0] mem_array [2**MEM_ADDR_WIDTH];

    mem_req_t req_q [MEM_REQ_QUEUE_DEPTH];
    logic [MEM_REQ_QUEUE_PTR_WIDTH-1:0] q_wr_ptr;
    logic [MEM_REQ_QUEUE_PTR_WIDTH-1:0] q_rd_ptr;
    logic [MEM_REQ_QUEUE_CNT_WIDTH-1:0] q_cnt;
    logic [MEM_REQ_QUEUE_CNT_WIDTH-1:0] q_cnt_next;
    logic q_push;
    logic q_pop;
    mem_req_t q_head;

    logic [MEM_REFRESH_CNT_WIDTH-1:0] refresh_cnt;
    logic refresh_active;
    logic issue_read;
    logic issue_write;

    // Read delay line, the last entry drives bank_rsp
    mem_rsp_t rsp_line [MEM_READ_LATENCY];

    // Every request seen is queued. Waitrequest upstream lags by the
    // register stages, and the slack leaves room for what is in flight
    assign q_push = bank_req.read || bank_req.write;
    assign q_pop = (q_cnt != '0) && !refresh_active;
    assign q_head = req_q[q_rd_ptr];

    assign issue_read = q_pop && q_head.read;
    assign issue_write = q_pop && q_head.write;

    always_comb
    begin
        q_cnt_next = q_cnt;
        if (q_push && !q_pop)
            q_cnt_next = q_cnt + 1'b1;
        else if (!q_push && q_pop)
            q_cnt_next = q_cnt - 1'b1;
    end

    always_ff @(posedge mem_fiu)
    begin
        if (q_push)
            req_q[q_wr_ptr] <= bank_req;
    end

    // Waitrequest is registered from the next count, so it follows the
    // queue level in the same cycle as the count itself
    always_ff @(posedge mem_fiu)
    begin
        if (reset)
        begin
            q_wr_ptr <= '0;
            q_rd_ptr <= '0;
            q_cnt <= '0;
            bank_waitrequest <= 1'b1;
        end
        else
        begin
            if (q_push)
                q_wr_ptr <= q_wr_ptr + 1'b1;
            if (q_pop)
                q_rd_ptr <= q_rd_ptr + 1'b1;
            q_cnt <= q_cnt_next;
            bank_waitrequest <=
                (q_cnt_next >= MEM_REQ_QUEUE_CNT_WIDTH'(MEM_WAITREQUEST_LEVEL));
        end
    end

    // Refresh takes the last MEM_REFRESH_CYCLES of each interval
    always_ff @(posedge mem_fiu)
    begin
        if (reset)
            refresh_cnt <= '0;
        else if (refresh_cnt == MEM_REFRESH_CNT_WIDTH'(MEM_REFRESH_INTERVAL - 1))
            refresh_cnt <= '0;
        else
            refresh_cnt <= refresh_cnt + 1'b1;
    end

    assign refresh_active =
        (refresh_cnt >= MEM_REFRESH_CNT_WIDTH'(MEM_REFRESH_INTERVAL - MEM_REFRESH_CYCLES));

    // Byte lane merge on writes
    always_ff @(posedge mem_fiu)
    begin
        if (issue_write)
        begin
            for (int b = 0; b < MEM_BE_WIDTH; b++)
            begin
                if (q_head.byteenable[b])
                    mem_array[q_head.address][b*8 +: 8] <= q_head.writedata[b*8 +: 8];
            end
        end
    end

    always_ff @(posedge mem_fiu)
    begin
        rsp_line[0].readdatavalid <= issue_read;
        rsp_line[0].readdata <= mem_array[q_head.address];
        for (int i = 1; i < MEM_READ_LATENCY; i++)
        begin
            rsp_line[i] <= rsp_line[i-1];
        end

        if (reset)
        begin
            for (int i = 0; i < MEM_READ_LATENCY; i++)
            begin
                rsp_line[i].readdatavalid <= 1'b0;
            end
        end
    end

    assign bank_rsp = rsp_line[MEM_READ_LATENCY-1];

endmodule

`default_nettype wire

/* logic/mem_subsystem_top.sv */
`timescale 1ns/1ns
`default_nettype none
// **************************************************
// Local memory subsystem. Two request ports go through the
// round-robin arbiter and the register stages into one bank
// **************************************************

module mem_subsystem_top
(
    input  wire logic mem_fiu,
    input  wire logic reset,

    input  mem_if_pkg::mem_req_t m0_req,
    output logic m0_waitrequest,
    output mem_if_pkg::mem_rsp_t m0_rsp,

    input  mem_if_pkg::mem_req_t m1_req,
    output logic m1_waitrequest,
    output mem_if_pkg::mem_rsp_t m1_rsp
);

    import mem_cfg_pkg::*;
    import mem_if_pkg::*;

    // Arbiter to register stages
    mem_req_t arb_req;
    logic afu_waitrequest;
    mem_rsp_t arb_rsp;

    // Register stages to bank
    mem_req_t bank_req;
    logic bank_waitrequest;
    mem_rsp_t bank_rsp;

    mem_arbiter arb
    (
        .mem_fiu(mem_fiu),
        .reset(reset),
        .m0_req(m0_req),
        .m0_waitrequest(m0_waitrequest),
        .m0_rsp(m0_rsp),
        .m1_req(m1_req),
        .m1_waitrequest(m1_waitrequest),
        .m1_rsp(m1_rsp),
        .arb_req(arb_req),
        .arb_waitrequest(afu_waitrequest),
        .arb_rsp(arb_rsp)
    );

    // The bank slack is sized from these same two counts
    avalon_mem_if_reg_simple
    #(
        .N_REG_STAGES(MEM_REG_STAGES),
        .N_WAITREQUEST_STAGES(MEM_WAITREQUEST_STAGES)
    )
    regs
    (
        .mem_fiu(mem_fiu),
        .reset(reset),
        .afu_req(arb_req),
        .afu_waitrequest(afu_waitrequest),
        .arb_rsp(arb_rsp),
        .bank_req(bank_req),
        .bank_waitrequest(bank_waitrequest),
        .bank_rsp(bank_rsp)
    );

    local_mem_bank bank
    (
        .mem_fiu(mem_fiu),
        .reset(reset),
        .bank_req(bank_req),
        .bank_waitrequest(bank_waitrequest),
        .bank_rsp(bank_rsp)
    );

endmodule

`default_nettype wire

/* dv/mem_subsystem_tb.sv */
`timescale 1ns/1ns
`default_nettype none
// **************************************************
// Self-checking random testbench for the memory subsystem.
// A memory model and per-port read FIFOs predict every readdata
// **************************************************

module mem_subsystem_tb;

    import mem_cfg_pkg::*;
    import mem_if_pkg::*;

    localparam int WINDOW = 64;
    localparam int BE_WRITES = 32;
    localparam int MIXED_REQS = 300;
    localparam int STREAM_REQS = 400;
    localparam int TOTAL_REQS = 2 * WINDOW + BE_WRITES + 2 * MIXED_REQS + 2 * STREAM_REQS;
    localparam int WATCHDOG_CYCLES = TOTAL_REQS * 40 + 2000;
    localparam int DRAIN_CYCLES = 200;

    bit mem_fiu;
    logic reset;
    mem_req_t m0_req;
    mem_req_t m1_req;
    logic m0_waitrequest;
    logic m1_waitrequest;
    mem_rsp_t m0_rsp;
    mem_rsp_t m1_rsp;

    // Request currently driven on each port, and whether it was taken
    mem_req_t cur_req [2];
    logic [1:0] accepted;

    // Pending stimulus per port where an all-zero entry is one idle cycle
    mem_req_t stim_q0 [$];
    mem_req_t stim_q1 [$];

    // Model of the bank contents and read data expected per port
    logic [MEM_DATA_WIDTH-1:0] mem_model [2**MEM_ADDR_WIDTH];
    logic [MEM_DATA_WIDTH-1:0] exp_q0 [$];
    logic [MEM_DATA_WIDTH-1:0] exp_q1 [$];

    logic [31:0] lcg_state;
    int value_errors;
    int other_errors;
    int reads_accepted [2];
    int reads_returned [2];
    int post_reset_cycles;
    logic have_last;
    logic last_port;

    assign m0_req = cur_req[0];
    assign m1_req = cur_req[1];

    mem_subsystem_top UUT
    (
        .mem_fiu(mem_fiu),
        .reset(reset),
        .m0_req(m0_req),
        .m0_waitrequest(m0_waitrequest),
        .m0_rsp(m0_rsp),
        .m1_req(m1_req),
        .m1_waitrequest(m1_waitrequest),
        .m1_rsp(m1_rsp)
    );

    initial
    begin
        mem_fiu = 1'b0;
    end

    always #10 mem_fiu = ~mem_fiu;

    // Only the upper half of the LCG state is used since the low bits cycle too fast
    function automatic logic [15:0] rand16();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:16];
    endfunction

    function automatic logic [31:0] rand32();
        logic [15:0] hi;
        hi = rand16();
        return {hi, rand16()};
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected)
        else
        begin
            value_errors++;
            $display("Fail: %s expected %0h, got %0h", name, expected, actual);
        end
    endtask

    task automatic push_stim(input int port, input mem_req_t req);
        if (port == 0)
            stim_q0.push_back(req);
        else
            stim_q1.push_back(req);
    endtask

    // Random single-word reads and writes inside the low address window
    task automatic gen_random(input int port, input int count, input bit with_idle);
        mem_req_t req;
        logic [15:0] r;
        for (int i = 0; i < count; i++)
        begin
            r = rand16();
            if (with_idle && r[15:14] == 2'b00)
                push_stim(port, '0);
            req = '0;
            req.read = r[13];
            req.write = !r[13];
            req.address = MEM_ADDR_WIDTH'(r[5:0]);
            req.writedata = rand32();
            req.byteenable = r[9:6];
            push_stim(port, req);
        end
    endtask

    // Take the next stimulus once the current request is gone or was idle
    task automatic advance_port(input int port);
        if (!(cur_req[port].read || cur_req[port].write) || accepted[port])
        begin
            cur_req[port] = '0;
            if (port == 0 && stim_q0.size() != 0)
                cur_req[0] = stim_q0.pop_front();
            else if (port == 1 && stim_q1.size() != 0)
                cur_req[1] = stim_q1.pop_front();
        end
    endtask

    // The bank runs requests in acceptance order, so the model is updated here
    task automatic record_accept(input int port, input mem_req_t req);
        if (req.write)
        begin
            for (int b = 0; b < MEM_BE_WIDTH; b++)
            begin
                if (req.byteenable[b])
                    mem_model[req.address][b*8 +: 8] = req.writedata[b*8 +: 8];
            end
        end
        else
        begin
            reads_accepted[port]++;
            if (port == 0)
                exp_q0.push_back(mem_model[req.address]);
            else
                exp_q1.push_back(mem_model[req.address]);
        end
    endtask

    task automatic check_response(input int port, input mem_rsp_t rsp);
        logic [MEM_DATA_WIDTH-1:0] expected;
        int pending;
        pending = (port == 0) ? exp_q0.size() : exp_q1.size();
        if (rsp.readdatavalid)
        begin
            reads_returned[port]++;
            assert (pending != 0)
            else
            begin
                other_errors++;
                $display("Read data arrived on port %0d with no read outstanding", port);
            end
            if (pending != 0)
            begin
                expected = (port == 0) ? exp_q0.pop_front() : exp_q1.pop_front();
                check_value($sformatf("m%0d_rsp.readdata", port), expected, rsp.readdata);
            end
        end
    endtask

    // Outputs are sampled at the falling edge, halfway between input changes
    always @(negedge mem_fiu)
    begin : monitor
        logic valid0;
        logic valid1;
        logic acc0;
        logic acc1;
        logic acc_port;
        if (reset || post_reset_cycles < 2)
        begin
            check_value("m0_waitrequest", 1'b1, m0_waitrequest);
            check_value("m1_waitrequest", 1'b1, m1_waitrequest);
            check_value("m0_rsp.readdatavalid", 1'b0, m0_rsp.readdatavalid);
            check_value("m1_rsp.readdatavalid", 1'b0, m1_rsp.readdatavalid);
        end
        if (reset)
        begin
            post_reset_cycles = 0;
            accepted = 2'b00;
        end
        else
        begin
            post_reset_cycles++;
            valid0 = m0_req.read || m0_req.write;
            valid1 = m1_req.read || m1_req.write;
            acc0 = valid0 && !m0_waitrequest;
            acc1 = valid1 && !m1_waitrequest;
            check_response(0, m0_rsp);
            check_response(1, m1_rsp);
            assert (!(acc0 && acc1))
            else
            begin
                other_errors++;
                $display("Both ports were accepted in the same cycle");
            end
            if (acc0 || acc1)
            begin
                acc_port = acc1;
                // With both ports waiting, the grant has to move to the other port
                if (valid0 && valid1 && have_last)
                begin
                    assert (acc_port != last_port)
                    else
                    begin
                        other_errors++;
                        $display("Port %0d was accepted twice in a row while port %0d waited",
                                 acc_port, !acc_port);
                    end
                end
                have_last = 1'b1;
                last_port = acc_port;
            end
            if (acc0)
                record_accept(0, m0_req);
            if (acc1)
                record_accept(1, m1_req);
            accepted = {acc1, acc0};
        end
    end

    // Drive all queued stimulus, then wait a bounded time for read data
    task automatic run_phase(input string name);
        while (stim_q0.size() != 0 || stim_q1.size() != 0 ||
               cur_req[0].read || cur_req[0].write || cur_req[1].read || cur_req[1].write)
        begin
            @(posedge mem_fiu);
            #2;
            advance_port(0);
            advance_port(1);
        end
        for (int i = 0; i < DRAIN_CYCLES && (exp_q0.size() != 0 || exp_q1.size() != 0); i++)
            @(posedge mem_fiu);
        assert (exp_q0.size() == 0 && exp_q1.size() == 0)
        else
        begin
            other_errors++;
            $display("Phase %s ended with %0d port 0 and %0d port 1 reads unanswered",
                     name, exp_q0.size(), exp_q1.size());
        end
        check_value("m0 read response count", reads_accepted[0], reads_returned[0]);
        check_value("m1 read response count", reads_accepted[1], reads_returned[1]);
    endtask

    initial
    begin
        mem_req_t req;
        reset = 1'b1;
        cur_req[0] = '0;
        cur_req[1] = '0;
        accepted = 2'b00;
        lcg_state = 32'hf868;
        value_errors = 0;
        other_errors = 0;
        reads_accepted[0] = 0;
        reads_accepted[1] = 0;
        reads_returned[0] = 0;
        reads_returned[1] = 0;
        post_reset_cycles = 0;
        have_last = 1'b0;
        last_port = 1'b0;
        repeat (5) @(posedge mem_fiu);
        #2;
        reset = 1'b0;

        // Full-word writes fill the window, so later reads never see unknown data
        for (int i = 0; i < WINDOW; i++)
        begin
            req = '0;
            req.write = 1'b1;
            req.address = MEM_ADDR_WIDTH'(i);
            req.writedata = rand32();
            req.byteenable = '1;
            push_stim(0, req);
        end
        for (int i = 0; i < BE_WRITES; i++)
        begin
            req = '0;
            req.write = 1'b1;
            req.address = MEM_ADDR_WIDTH'(rand16() % WINDOW);
            req.writedata = rand32();
            req.byteenable = MEM_BE_WIDTH'(rand16() >> 8);
            push_stim(0, req);
        end
        for (int i = 0; i < WINDOW; i++)
        begin
            req = '0;
            req.read = 1'b1;
            req.address = MEM_ADDR_WIDTH'(i);
            push_stim(0, req);
        end
        run_phase("byte enables");

        gen_random(0, MIXED_REQS, 1'b1);
        gen_random(1, MIXED_REQS, 1'b1);
        run_phase("mixed traffic");

        // Back-to-back requests on both ports across several refresh pauses
        gen_random(0, STREAM_REQS, 1'b0);
        gen_random(1, STREAM_REQS, 1'b0);
        run_phase("back-pressure");

        $display("Errors: %0d value, %0d other", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge mem_fiu);
        $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
logic/mem_cfg_pkg.sv
logic/mem_if_pkg.sv
logic/avalon_mem_if_reg_simple.sv
logic/mem_arbiter.sv
logic/local_mem_bank.sv
logic/mem_subsystem_top.sv
dv/mem_subsystem_tb.sv
